// ==== run.sh ====
#!/bin/bash
# build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module dcacheTb -o simv

status=0
./obj_dir/simv > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log || [ "$status" -ne 0 ]; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

// ==== tb.f ====
+incdir+verilog
verilog/dcachePkg.sv
verilog/dcacheTagWays.sv
verilog/dcacheWayData.sv
verilog/dcacheHitSelect.sv
verilog/dcacheTop.sv
verif/tbClockGen.sv
verif/dcacheChk.sv
verif/dcacheTb.sv

// ==== verif/dcacheChk.sv ====
// bound assertions on the tag unit hit vector and data write command
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcacheChk (
	input logic                   clk,
	input logic                   rst,
	input logic [`CACHE_WAYS-1:0] hitWays_i,
	input logic                   wr_i,
	input logic                   invLine_i,
	input logic                   invAll_i,
	input logic                   dataWr_i
);

	// at most one way holds a given address
	hitOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(hitWays_i))
		else $error("more than one way hits the same address");

	// whole cache is empty the cycle after a flush
	flushMiss: assert property (@(posedge clk) disable iff (rst) invAll_i |=> (hitWays_i == '0))
		else $error("a way still hits after invalidate-all");

	// bank write command trails an accepted write by one edge
	wrDelay: assert property (@(posedge clk) disable iff (rst)
		dataWr_i == $past(wr_i && !invLine_i && !invAll_i))
		else $error("data write strobe does not follow the write command");

endmodule

bind dcacheTagWays dcacheChk uChk (
	.clk       (clk),
	.rst       (rst),
	.hitWays_i (hitWays_o),
	.wr_i      (wr_i),
	.invLine_i (invLine_i),
	.invAll_i  (invAll_i),
	.dataWr_i  (dataWr_o)
);

// ==== verif/dcacheTb.sv ====
// random-stimulus testbench for the data cache lookup array against a reference model
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcacheTb import dcachePkg::*; ();

	localparam int N_OPS = 3000;
	localparam int MAX_CYCLES = N_OPS * 20 + 100;

	logic clk;
	logic rst;
	logic [`ADDR_W-1:0] adr;
	logic wr;
	logic invLine;
	logic invAll;
	logic [`LINE_BYTES-1:0] sel;
	cacheLine_t line;
	logic hit;
	logic [`WORD_W-1:0] word;
	logic [FAULT_W-1:0] fault;

	// reference state
	// known marks a slot whose bytes were written at least once
	tagBits_t mTag [`CACHE_WAYS][`CACHE_SETS];
	logic mValid [`CACHE_WAYS][`CACHE_SETS];
	logic mKnown [`CACHE_WAYS][`CACHE_SETS];
	logic [7:0] mData [`CACHE_WAYS][`CACHE_SETS][`LINE_BYTES];
	logic [15:0] mLfsr;
	// data write waiting for the following edge
	logic pendWr;
	wayIdx_t pendWay;
	setIdx_t pendSet;
	logic [`LINE_BYTES-1:0] pendSel;
	cacheLine_t pendLine;
	// address pool of 24 tags over 4 sets
	tagBits_t tagPool [24];
	setIdx_t setPool [4];
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	tbClockGen uClk (
		.clk_o (clk),
		.rst_o (rst)
	);

	dcacheTop DUT (
		.clk       (clk),
		.rst       (rst),
		.adr_i     (adr),
		.wr_i      (wr),
		.sel_i     (sel),
		.line_i    (line),
		.invLine_i (invLine),
		.invAll_i  (invAll),
		.hit_o     (hit),
		.word_o    (word),
		.fault_o   (fault)
	);

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------

	task automatic compareValue(input logic [63:0] exp, input logic [63:0] act, input string what);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAILED at %0t: %s expected %0h got %0h", $time, what, exp, act);
		end
	endtask

	// way of the model that holds the address or -1 on a miss
	function automatic int modelWay(input logic [`ADDR_W-1:0] a);
		setIdx_t s;
		s = a[OFS_W +: SET_W];
		modelWay = -1;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (mValid[w][s] && mTag[w][s] == a[`ADDR_W-1 -: TAG_W]) begin
				modelWay = w;
			end
		end
	endfunction

	// eight bytes from the offset on with zero past the data bytes
	function automatic logic [`WORD_W-1:0] modelWord(input int w, input setIdx_t s, input int ofs);
		logic [`WORD_W-1:0] r;
		r = '0;
		for (int i = 0; i < 8; i++) begin
			if (ofs + i < DATA_BYTES) begin
				r[i*8 +: 8] = mData[w][s][ofs + i];
			end
		end
		return r;
	endfunction

	task automatic checkOutputs();
		int w;
		setIdx_t s;
		s = adr[OFS_W +: SET_W];
		w = modelWay(adr);
		compareValue(64'(w >= 0), 64'(hit), "hit");
		if (w < 0) begin
			compareValue(64'(0), word, "word on miss");
			compareValue(64'(0), 64'(fault), "fault on miss");
		end else if (mKnown[w][s]) begin
			compareValue(modelWord(w, s, int'(adr[OFS_W-1:0])), word, "word");
			compareValue(64'(mData[w][s][DATA_BYTES][FAULT_W-1:0]), 64'(fault), "fault");
		end
	endtask

	// model update for the coming rising edge
	task automatic modelEdge();
		int w;
		setIdx_t s;
		s = adr[OFS_W +: SET_W];
		w = modelWay(adr);
		// bytes of the previous write land first
		if (pendWr) begin
			for (int b = 0; b < `LINE_BYTES; b++) begin
				if (pendSel[b]) begin
					mData[pendWay][pendSet][b] = pendLine.b[b];
				end
			end
			mKnown[pendWay][pendSet] = 1'b1;
		end
		pendWr = 1'b0;
		if (invAll) begin
			foreach (mValid[i, j]) begin
				mValid[i][j] = 1'b0;
			end
		end else if (invLine) begin
			if (w >= 0) begin
				mValid[w][s] = 1'b0;
			end
		end else if (wr) begin
			if (w < 0) begin
				// victim from the two low lfsr bits and then one lfsr step
				w = int'(mLfsr[1:0]);
				mTag[w][s] = adr[`ADDR_W-1 -: TAG_W];
				mValid[w][s] = 1'b1;
				mLfsr = {mLfsr[14:0], mLfsr[15] ^ mLfsr[13] ^ mLfsr[12] ^ mLfsr[10]};
			end
			pendWr = 1'b1;
			pendWay = wayIdx_t'(w);
			pendSet = s;
			pendSel = sel;
			pendLine = line;
		end
	endtask

	task automatic applyOp(input int n);
		int r;
		int ti;
		r = int'($urandom % 100);
		// half the picks come from a few hot tags so lines get reused
		ti = (r % 2 == 0) ? int'($urandom % 6) : int'($urandom % 24);
		adr = {tagPool[ti], setPool[int'($urandom % 4)], 5'($urandom)};
		wr = 1'b0;
		invLine = 1'b0;
		invAll = 1'b0;
		sel = '0;
		// reads only right after reset
		if (n < 20) begin
			r = 99;
		end
		if (r < 2) begin
			invAll = 1'b1;
		end else if (r < 8) begin
			invLine = 1'b1;
		end else if (r < 40) begin
			wr = 1'b1;
			for (int b = 0; b < `LINE_BYTES; b++) begin
				line.b[b] = 8'($urandom);
			end
			// partial writes only to resident lines
			// a miss fills the whole line
			if (modelWay(adr) >= 0 && r < 30) begin
				sel = {1'($urandom), 32'($urandom)};
			end else begin
				sel = '1;
			end
		end
	endtask

	// --------------------------------------------------
	// run
	// --------------------------------------------------

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		void'($urandom(82912));
		adr = '0;
		wr = 1'b0;
		sel = '0;
		line = '0;
		invLine = 1'b0;
		invAll = 1'b0;
		foreach (mValid[i, j]) begin
			mValid[i][j] = 1'b0;
		end
		foreach (mKnown[i, j]) begin
			mKnown[i][j] = 1'b0;
		end
		mLfsr = 16'hACE1;
		pendWr = 1'b0;
		for (int i = 0; i < 24; i++) begin
			tagPool[i] = tagBits_t'($urandom);
		end
		for (int i = 0; i < 4; i++) begin
			setPool[i] = setIdx_t'(i * 4 + 1);
		end
		// reset is sampled at clock edges only
		@(posedge clk);
		while (rst) begin
			@(posedge clk);
		end
		for (int n = 0; n < N_OPS; n++) begin
			@(posedge clk);
			#2;
			applyOp(n);
			// outputs settled well before the next edge
			#10;
			checkOutputs();
			modelEdge();
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== verif/tbClockGen.sv ====
// testbench clock and synchronous reset source for the data cache
`timescale 1ns/100ps

module tbClockGen (
	output logic clk_o,
	output logic rst_o
);

	// 20 ns period
	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	// reset held over eight rising edges, released just after the last
	initial begin
		rst_o = 1'b1;
		repeat (8) @(posedge clk_o);
		#2;
		rst_o = 1'b0;
	end

endmodule

// ==== verilog/dcacheHitSelect.sv ====
// hit way line mux with aligned word extraction and fault code readout
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcacheHitSelect import dcachePkg::*; (
	input  logic [`CACHE_WAYS-1:0] hitWays_i,
	input  cacheLine_t             wayLines_i [`CACHE_WAYS],
	input  logic [OFS_W-1:0]       offset_i,
	output logic                   hit_o,
	output logic [`WORD_W-1:0]     word_o,
	output logic [FAULT_W-1:0]     fault_o
);

	cacheLine_t hitLine;
	logic [DATA_W-1:0] shifted;

	// --------------------------------------------------
	// way mux
	// --------------------------------------------------

	// and-or mux, hitWays_i is zero or one-hot
	// so a miss leaves the line at zero
	always_comb begin
		hitLine = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (hitWays_i[w]) begin
				hitLine = hitLine | wayLines_i[w];
			end
		end
	end

	// --------------------------------------------------
	// word align
	// --------------------------------------------------

	// byte offset to bit shift, zeros come in past byte 31
	assign shifted = hitLine.f.data >> {offset_i, 3'b000};

	assign hit_o = |hitWays_i;
	assign word_o = shifted[`WORD_W-1:0];
	// fault code sits in the low status bits
	assign fault_o = hitLine.f.status[FAULT_W-1:0];

endmodule

// ==== verilog/dcachePkg.sv ====
// data cache line layout, the dual-view line union and address field types
`include "dcache_config.svh"

package dcachePkg;

	// data bytes exclude the status byte at the top of the line
	localparam int DATA_BYTES = `LINE_BYTES - 1;
	localparam int DATA_W = DATA_BYTES * 8;
	localparam int OFS_W = $clog2(DATA_BYTES);
	localparam int SET_W = $clog2(`CACHE_SETS);
	localparam int TAG_W = `ADDR_W - SET_W - OFS_W;
	localparam int WAY_W = $clog2(`CACHE_WAYS);
	// low bits of the status byte
	localparam int FAULT_W = 3;

	// field view, used when a line is read
	typedef struct packed {
		logic [7:0] status;
		logic [DATA_W-1:0] data;
	} lineFields_t;

	// byte view, used for byte-enable writes
	typedef logic [`LINE_BYTES-1:0][7:0] lineBytes_t;

	// same 264 bits, two decodings
	typedef union packed {
		lineFields_t f;
		lineBytes_t b;
	} cacheLine_t;

	typedef logic [SET_W-1:0] setIdx_t;
	typedef logic [TAG_W-1:0] tagBits_t;
	typedef logic [WAY_W-1:0] wayIdx_t;

endpackage

// ==== verilog/dcacheTagWays.sv ====
// four-way tag and valid store with tag compare, LFSR victim choice and invalidation
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcacheTagWays import dcachePkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`ADDR_W-1:0]     adr_i,
	input  logic                   wr_i,
	input  logic                   invLine_i,
	input  logic                   invAll_i,
	output logic [`CACHE_WAYS-1:0] hitWays_o,
	output logic                   dataWr_o,
	output wayIdx_t                dataWay_o,
	output setIdx_t                dataSet_o
);

	// lfsr start value after reset
	localparam logic [15:0] LFSR_SEED = 16'hACE1;

	// tag and valid state per way
	tagBits_t tagMem [`CACHE_WAYS][`CACHE_SETS];
	logic [`CACHE_SETS-1:0] validMem [`CACHE_WAYS];

	logic [15:0] lfsr;
	logic lfsrFb;
	setIdx_t adrSet;
	tagBits_t adrTag;
	logic anyHit;
	wayIdx_t hitWay;
	wayIdx_t victimWay;
	wayIdx_t wrWay;
	logic cmdWr;
	logic allocate;

	// --------------------------------------------------
	// address split and compare
	// --------------------------------------------------

	// bits 4:0 are the byte offset, handled in the hit selector
	assign adrSet = adr_i[OFS_W +: SET_W];
	assign adrTag = adr_i[`ADDR_W-1 -: TAG_W];

	// all ways compared in parallel, combinational on adr_i
	for (genvar g = 0; g < `CACHE_WAYS; g++) begin : gCmp
		assign hitWays_o[g] = validMem[g][adrSet] && (tagMem[g][adrSet] == adrTag);
	end

	assign anyHit = |hitWays_o;

	// encode the hitting way, at most one bit is set
	always_comb begin
		hitWay = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (hitWays_o[w]) begin
				hitWay = wayIdx_t'(w);
			end
		end
	end

	// --------------------------------------------------
	// command decode
	// --------------------------------------------------

	// invalidation wins over a write in the same cycle
	assign cmdWr = wr_i & ~invLine_i & ~invAll_i;
	// a write miss claims the victim way
	assign allocate = cmdWr & ~anyHit;
	assign victimWay = lfsr[WAY_W-1:0];
	// write hit keeps its way, miss goes to the victim
	assign wrWay = anyHit ? hitWay : victimWay;

	// --------------------------------------------------
	// victim lfsr
	// --------------------------------------------------

	// taps 16, 14, 13, 11
	assign lfsrFb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr <= LFSR_SEED;
		end else if (allocate) begin
			// one step per allocation
			lfsr <= {lfsr[14:0], lfsrFb};
		end
	end

	// --------------------------------------------------
	// valid and tag update
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				validMem[w] <= '0;
			end
		end else if (invAll_i) begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				validMem[w] <= '0;
			end
		end else if (invLine_i) begin
			// only the way that holds the address is dropped
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				if (hitWays_o[w]) begin
					validMem[w][adrSet] <= 1'b0;
				end
			end
		end else if (allocate) begin
			validMem[victimWay][adrSet] <= 1'b1;
		end
	end

	// new tag lands at the write edge
	always_ff @(posedge clk) begin
		if (allocate) begin
			tagMem[victimWay][adrSet] <= adrTag;
		end
	end

	// --------------------------------------------------
	// data bank command, one cycle behind the tags
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			dataWr_o <= 1'b0;
		end else begin
			dataWr_o <= cmdWr;
		end
	end

	always_ff @(posedge clk) begin
		if (cmdWr) begin
			dataWay_o <= wrWay;
			dataSet_o <= adrSet;
		end
	end

endmodule

// ==== verilog/dcacheTop.sv ====
// level-one data cache lookup array built from the tag unit, data banks and hit selector
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcacheTop import dcachePkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`ADDR_W-1:0]     adr_i,
	input  logic                   wr_i,
	input  logic [`LINE_BYTES-1:0] sel_i,
	input  cacheLine_t             line_i,
	input  logic                   invLine_i,
	input  logic                   invAll_i,
	output logic                   hit_o,
	output logic [`WORD_W-1:0]     word_o,
	output logic [FAULT_W-1:0]     fault_o
);

	// lookup result of the tag compare
	logic [`CACHE_WAYS-1:0] hitWays;
	// registered write command for the banks
	logic dataWr;
	wayIdx_t dataWay;
	setIdx_t dataSet;
	// all lines of the lookup set
	cacheLine_t wayLines [`CACHE_WAYS];

	// --------------------------------------------------
	// tags
	// --------------------------------------------------

	dcacheTagWays uTags (
		.clk       (clk),
		.rst       (rst),
		.adr_i     (adr_i),
		.wr_i      (wr_i),
		.invLine_i (invLine_i),
		.invAll_i  (invAll_i),
		.hitWays_o (hitWays),
		.dataWr_o  (dataWr),
		.dataWay_o (dataWay),
		.dataSet_o (dataSet)
	);

	// --------------------------------------------------
	// data
	// --------------------------------------------------

	// read set comes straight from the address
	dcacheWayData uData (
		.clk        (clk),
		.wr_i       (dataWr),
		.way_i      (dataWay),
		.set_i      (dataSet),
		.sel_i      (sel_i),
		.line_i     (line_i),
		.rdSet_i    (adr_i[OFS_W +: SET_W]),
		.wayLines_o (wayLines)
	);

	dcacheHitSelect uSel (
		.hitWays_i  (hitWays),
		.wayLines_i (wayLines),
		.offset_i   (adr_i[OFS_W-1:0]),
		.hit_o      (hit_o),
		.word_o     (word_o),
		.fault_o    (fault_o)
	);

endmodule

// ==== verilog/dcacheWayData.sv ====
// four line data banks with delayed byte-enable writes and a combinational set read
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcacheWayData import dcachePkg::*; (
	input  logic                   clk,
	input  logic                   wr_i,
	input  wayIdx_t                way_i,
	input  setIdx_t                set_i,
	input  logic [`LINE_BYTES-1:0] sel_i,
	input  cacheLine_t             line_i,
	input  setIdx_t                rdSet_i,
	output cacheLine_t             wayLines_o [`CACHE_WAYS]
);

	// write payload held until the way is known
	logic [`LINE_BYTES-1:0] selQ;
	cacheLine_t lineQ;

	// --------------------------------------------------
	// payload capture
	// --------------------------------------------------

	// captured at the tag edge, used one edge later
	always_ff @(posedge clk) begin
		selQ <= sel_i;
		lineQ <= line_i;
	end

	// --------------------------------------------------
	// banks
	// --------------------------------------------------

	for (genvar g = 0; g < `CACHE_WAYS; g++) begin : gBank
		cacheLine_t bank [`CACHE_SETS];

		// byte view of the union, one enable per byte
		always_ff @(posedge clk) begin
			if (wr_i && (way_i == wayIdx_t'(g))) begin
				for (int b = 0; b < `LINE_BYTES; b++) begin
					if (selQ[b]) begin
						bank[set_i].b[b] <= lineQ.b[b];
					end
				end
			end
		end

		// every way of the lookup set at once
		assign wayLines_o[g] = bank[rdSet_i];
	end

endmodule

// ==== verilog/dcache_config.svh ====
// data cache sizing macros shared by the package and the lookup array RTL
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// --------------------------------------------------
// geometry
// --------------------------------------------------

// total number of lines held by the cache
`define CACHE_LINES 64

// associativity
`define CACHE_WAYS 4

// sets follow from lines and ways
`define CACHE_SETS (`CACHE_LINES / `CACHE_WAYS)

// --------------------------------------------------
// widths
// --------------------------------------------------

// cpu byte address
`define ADDR_W 32

// 32 data bytes plus one status byte
`define LINE_BYTES 33

// read word returned on a hit
`define WORD_W 64

`endif
